// ==== source/exStage_settings.svh ====
// Width settings for the execute stage datapath and its control codes
`ifndef EXSTAGE_SETTINGS_SVH
`define EXSTAGE_SETTINGS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Data and address width of the core
`define XLEN 32

//////////////////////////////
// Control fields
//////////////////////////////

// Width of the ALU operation code
`define ALU_OP_WIDTH 4

// Immediate field of the CSR immediate forms
`define ZIMM_WIDTH 5

`endif

// ==== source/exStagePkg.sv ====
// Instruction class and ALU operation types with the RV32I function field codes
`default_nettype none

`include "exStage_settings.svh"

package exStagePkg;

	// Decoded instruction class handed over by the requester
	typedef enum logic [2:0] {
		aluR,
		aluLoadStore,
		aluBranch,
		aluLui,
		aluAuipc,
		aluIComp,
		aluJ,
		aluCsr
	} aluCtrlT;

	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		opAdd,
		opSub,
		opSubu,
		opXor,
		opOr,
		opAnd,
		opSll,
		opSrl,
		opSra,
		opSlt,
		opSltu,
		opLui,
		opAuipc,
		opPass,
		opClear
	} aluOpT;

	//////////////////////////////
	// funct3 codes
	//////////////////////////////
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Sltu = 3'b011;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Srl = 3'b101;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	// Codes 000 and 100 are not CSR forms
	localparam logic [2:0] f3Csrrw = 3'b001;
	localparam logic [2:0] f3Csrrs = 3'b010;
	localparam logic [2:0] f3Csrrc = 3'b011;
	localparam logic [2:0] f3Csrrwi = 3'b101;
	localparam logic [2:0] f3Csrrsi = 3'b110;
	localparam logic [2:0] f3Csrrci = 3'b111;

	// The f7Alt code in funct7 turns ADD into SUB and SRL into SRA
	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt = 7'b0100000;

endpackage

`default_nettype wire

// ==== source/exControl.sv ====
// Handshake FSM of the execute stage that sequences capture, compute and acknowledge
`timescale 1ns/100ps
`default_nettype none

module exControl (
	input wire logic clk,
	input wire logic rstN,
	input wire logic req,
	output logic ack,
	output logic captureEn,
	output logic resultEn
);

	typedef enum logic [1:0] {
		idle,
		busy,
		done
	} stateT;

	stateT state;

	// Capture happens on the first edge that sees req in idle
	assign captureEn = (state == idle) && req;
	assign resultEn = (state == busy);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= idle;
			ack <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (req)
						state <= busy;
				end
				busy: begin
					state <= done;
					ack <= 1'b1;
				end
				done: begin
					// Hold ack and the results until the requester lets go
					if (!req) begin
						state <= idle;
						ack <= 1'b0;
					end
				end
				default: begin
					state <= idle;
					ack <= 1'b0;
				end
			endcase
		end
	end

	//////////////////////////////
	// Protocol checks
	//////////////////////////////
	enablesExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(captureEn && resultEn));

	ackFallsAfterReq: assert property (@(posedge clk) disable iff (!rstN)
		$fell(ack) |-> !$past(req));

	resultFollowsCapture: assert property (@(posedge clk) disable iff (!rstN)
		captureEn |=> resultEn);

endmodule

`default_nettype wire

// ==== source/aluDecode.sv ====
// ALU control decode that maps the captured class and function fields to an ALU operation
`timescale 1ns/100ps
`default_nettype none

module aluDecode (
	input wire logic clk,
	input wire logic rstN,
	input wire logic captureEn,
	input wire exStagePkg::aluCtrlT aluCtrl,
	input wire logic [2:0] funct3,
	input wire logic [6:0] funct7,
	output exStagePkg::aluCtrlT aluCtrlQ,
	output logic [2:0] funct3Q,
	output exStagePkg::aluOpT aluOp,
	output logic csrImm
);

	logic [6:0] funct7Q;
	logic altForm;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			aluCtrlQ <= exStagePkg::aluR;
			funct3Q <= '0;
			funct7Q <= '0;
		end else if (captureEn) begin
			aluCtrlQ <= aluCtrl;
			funct3Q <= funct3;
			funct7Q <= funct7;
		end
	end

	assign altForm = (funct7Q == exStagePkg::f7Alt);

	always_comb begin
		csrImm = 1'b0;
		aluOp = exStagePkg::opAdd;
		case (aluCtrlQ)
			exStagePkg::aluR, exStagePkg::aluIComp: begin
				case (funct3Q)
					// Only the register form has a subtract
					exStagePkg::f3AddSub: aluOp = (altForm && aluCtrlQ == exStagePkg::aluR) ?
						exStagePkg::opSub : exStagePkg::opAdd;
					exStagePkg::f3Sll: aluOp = exStagePkg::opSll;
					exStagePkg::f3Slt: aluOp = exStagePkg::opSlt;
					exStagePkg::f3Sltu: aluOp = exStagePkg::opSltu;
					exStagePkg::f3Xor: aluOp = exStagePkg::opXor;
					exStagePkg::f3Srl: aluOp = altForm ? exStagePkg::opSra : exStagePkg::opSrl;
					exStagePkg::f3Or: aluOp = exStagePkg::opOr;
					exStagePkg::f3And: aluOp = exStagePkg::opAnd;
					default: aluOp = exStagePkg::opAdd;
				endcase
			end
			exStagePkg::aluBranch: begin
				if (funct3Q == exStagePkg::f3Bltu || funct3Q == exStagePkg::f3Bgeu)
					aluOp = exStagePkg::opSubu;
				else
					aluOp = exStagePkg::opSub;
			end
			exStagePkg::aluLui: aluOp = exStagePkg::opLui;
			exStagePkg::aluAuipc: aluOp = exStagePkg::opAuipc;
			exStagePkg::aluCsr: begin
				csrImm = (funct3Q == exStagePkg::f3Csrrwi) || (funct3Q == exStagePkg::f3Csrrsi) ||
					(funct3Q == exStagePkg::f3Csrrci);
				case (funct3Q)
					exStagePkg::f3Csrrs, exStagePkg::f3Csrrsi: aluOp = exStagePkg::opOr;
					exStagePkg::f3Csrrc, exStagePkg::f3Csrrci: aluOp = exStagePkg::opClear;
					default: aluOp = exStagePkg::opPass;
				endcase
			end
			// Load/store and jump both need an address sum
			default: aluOp = exStagePkg::opAdd;
		endcase
	end

	csrImmOnlyForCsr: assert property (@(posedge clk) disable iff (!rstN)
		csrImm |-> (aluCtrlQ == exStagePkg::aluCsr));

endmodule

`default_nettype wire

// ==== source/operandSelect.sv ====
// Operand capture and selection of ALU operands A and B by instruction class
`timescale 1ns/100ps
`default_nettype none

`include "exStage_settings.svh"

module operandSelect (
	input wire logic clk,
	input wire logic rstN,
	input wire logic captureEn,
	input wire logic [`XLEN-1:0] rs1Data,
	input wire logic [`XLEN-1:0] rs2Data,
	input wire logic [`XLEN-1:0] imm,
	input wire logic [`XLEN-1:0] pc,
	input wire logic [`XLEN-1:0] csrRdata,
	input wire logic [`ZIMM_WIDTH-1:0] zimm,
	input wire exStagePkg::aluCtrlT aluCtrlQ,
	input wire logic csrImm,
	output logic [`XLEN-1:0] opA,
	output logic [`XLEN-1:0] opB
);

	logic [`XLEN-1:0] rs1Q;
	logic [`XLEN-1:0] rs2Q;
	logic [`XLEN-1:0] immQ;
	logic [`XLEN-1:0] pcQ;
	logic [`XLEN-1:0] csrRdataQ;
	logic [`ZIMM_WIDTH-1:0] zimmQ;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rs1Q <= '0;
			rs2Q <= '0;
			immQ <= '0;
			pcQ <= '0;
			csrRdataQ <= '0;
			zimmQ <= '0;
		end else if (captureEn) begin
			rs1Q <= rs1Data;
			rs2Q <= rs2Data;
			immQ <= imm;
			pcQ <= pc;
			csrRdataQ <= csrRdata;
			zimmQ <= zimm;
		end
	end

	always_comb begin
		case (aluCtrlQ)
			exStagePkg::aluAuipc, exStagePkg::aluJ: opA = pcQ;
			// The old CSR value is the A side of the read-modify-write
			exStagePkg::aluCsr: opA = csrRdataQ;
			default: opA = rs1Q;
		endcase
	end

	always_comb begin
		case (aluCtrlQ)
			exStagePkg::aluR, exStagePkg::aluBranch: opB = rs2Q;
			exStagePkg::aluJ: opB = `XLEN'd4;
			exStagePkg::aluCsr: opB = csrImm ? {{(`XLEN-`ZIMM_WIDTH){1'b0}}, zimmQ} : rs1Q;
			default: opB = immQ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/aluCore.sv ====
// ALU of the execute stage with a result register loaded on the result pulse
`timescale 1ns/100ps
`default_nettype none

`include "exStage_settings.svh"

module aluCore (
	input wire logic clk,
	input wire logic rstN,
	input wire logic resultEn,
	input wire exStagePkg::aluOpT aluOp,
	input wire logic [`XLEN-1:0] opA,
	input wire logic [`XLEN-1:0] opB,
	output logic [`XLEN-1:0] result
);

	logic [4:0] shamt;
	logic [`XLEN-1:0] aluOut;

	// Shift amount is always the low five bits
	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			exStagePkg::opAdd: aluOut = opA + opB;
			exStagePkg::opAuipc: aluOut = opA + opB;
			// Both subtract forms give the same wrapped difference
			exStagePkg::opSub: aluOut = opA - opB;
			exStagePkg::opSubu: aluOut = opA - opB;
			exStagePkg::opXor: aluOut = opA ^ opB;
			exStagePkg::opOr: aluOut = opA | opB;
			exStagePkg::opAnd: aluOut = opA & opB;
			exStagePkg::opSll: aluOut = opA << shamt;
			exStagePkg::opSrl: aluOut = opA >> shamt;
			exStagePkg::opSra: aluOut = $unsigned($signed(opA) >>> shamt);
			exStagePkg::opSlt: begin
				aluOut = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
			end
			exStagePkg::opSltu: begin
				aluOut = {{(`XLEN-1){1'b0}}, (opA < opB)};
			end
			exStagePkg::opLui: aluOut = opB;
			exStagePkg::opPass: aluOut = opB;
			// Clear the CSR bits that are set in B
			exStagePkg::opClear: aluOut = opA & ~opB;
			default: aluOut = opA + opB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			result <= '0;
		else if (resultEn)
			result <= aluOut;
	end

endmodule

`default_nettype wire

// ==== source/branchCompare.sv ====
// Branch condition evaluation with a taken flag loaded on the result pulse
`timescale 1ns/100ps
`default_nettype none

`include "exStage_settings.svh"

module branchCompare (
	input wire logic clk,
	input wire logic rstN,
	input wire logic resultEn,
	input wire exStagePkg::aluCtrlT aluCtrlQ,
	input wire logic [2:0] funct3Q,
	input wire logic [`XLEN-1:0] opA,
	input wire logic [`XLEN-1:0] opB,
	output logic branchTaken
);

	logic isEqual;
	logic lessSigned;
	logic lessUnsigned;
	logic condition;

	assign isEqual = (opA == opB);
	assign lessSigned = ($signed(opA) < $signed(opB));
	assign lessUnsigned = (opA < opB);

	always_comb begin
		case (funct3Q)
			exStagePkg::f3Beq: condition = isEqual;
			exStagePkg::f3Bne: condition = !isEqual;
			exStagePkg::f3Blt: condition = lessSigned;
			exStagePkg::f3Bge: condition = !lessSigned;
			exStagePkg::f3Bltu: condition = lessUnsigned;
			exStagePkg::f3Bgeu: condition = !lessUnsigned;
			default: condition = 1'b0;
		endcase
	end

	// Only the branch class may report a taken branch
	always_ff @(posedge clk) begin
		if (!rstN)
			branchTaken <= 1'b0;
		else if (resultEn)
			branchTaken <= condition && (aluCtrlQ == exStagePkg::aluBranch);
	end

endmodule

`default_nettype wire

// ==== source/exUnit.sv ====
// Execute stage top level that joins the handshake control with the ALU datapath
`timescale 1ns/100ps
`default_nettype none

`include "exStage_settings.svh"

module exUnit (
	input wire logic clk,
	input wire logic rstN,
	input wire logic req,
	output logic ack,
	input wire exStagePkg::aluCtrlT aluCtrl,
	input wire logic [2:0] funct3,
	input wire logic [6:0] funct7,
	input wire logic [`XLEN-1:0] rs1Data,
	input wire logic [`XLEN-1:0] rs2Data,
	input wire logic [`XLEN-1:0] imm,
	input wire logic [`XLEN-1:0] pc,
	input wire logic [`XLEN-1:0] csrRdata,
	input wire logic [`ZIMM_WIDTH-1:0] zimm,
	output logic [`XLEN-1:0] result,
	output logic branchTaken
);

	logic captureEn;
	logic resultEn;
	exStagePkg::aluCtrlT aluCtrlQ;
	logic [2:0] funct3Q;
	exStagePkg::aluOpT aluOp;
	logic csrImm;
	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;

	exControl u_exControl (
		.clk(clk), .rstN(rstN), .req(req), .ack(ack),
		.captureEn(captureEn), .resultEn(resultEn)
	);

	aluDecode u_aluDecode (
		.clk(clk), .rstN(rstN), .captureEn(captureEn),
		.aluCtrl(aluCtrl), .funct3(funct3), .funct7(funct7),
		.aluCtrlQ(aluCtrlQ), .funct3Q(funct3Q), .aluOp(aluOp), .csrImm(csrImm)
	);

	operandSelect u_operandSelect (
		.clk(clk), .rstN(rstN), .captureEn(captureEn),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .pc(pc),
		.csrRdata(csrRdata), .zimm(zimm), .aluCtrlQ(aluCtrlQ), .csrImm(csrImm),
		.opA(opA), .opB(opB)
	);

	aluCore u_aluCore (
		.clk(clk), .rstN(rstN), .resultEn(resultEn), .aluOp(aluOp),
		.opA(opA), .opB(opB), .result(result)
	);

	branchCompare u_branchCompare (
		.clk(clk), .rstN(rstN), .resultEn(resultEn), .aluCtrlQ(aluCtrlQ),
		.funct3Q(funct3Q), .opA(opA), .opB(opB), .branchTaken(branchTaken)
	);

endmodule

`default_nettype wire

// ==== dv/exChecker.sv ====
// Reference model and protocol monitor that checks the execute stage responses
`timescale 1ns/100ps
`default_nettype none

`include "exStage_settings.svh"

module exChecker (
	input wire logic clk,
	input wire logic rstN,
	input wire logic req,
	input wire logic ack,
	input wire exStagePkg::aluCtrlT aluCtrl,
	input wire logic [2:0] funct3,
	input wire logic [6:0] funct7,
	input wire logic [`XLEN-1:0] rs1Data,
	input wire logic [`XLEN-1:0] rs2Data,
	input wire logic [`XLEN-1:0] imm,
	input wire logic [`XLEN-1:0] pc,
	input wire logic [`XLEN-1:0] csrRdata,
	input wire logic [`ZIMM_WIDTH-1:0] zimm,
	input wire logic [`XLEN-1:0] result,
	input wire logic branchTaken,
	output int mismatchCount,
	output int faultCount,
	output int compareCount
);

	exStagePkg::aluCtrlT cls;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [`XLEN-1:0] rs1;
	logic [`XLEN-1:0] rs2;
	logic [`XLEN-1:0] immL;
	logic [`XLEN-1:0] pcL;
	logic [`XLEN-1:0] csrL;
	logic [`ZIMM_WIDTH-1:0] zimmL;
	logic [`XLEN-1:0] heldResult;
	logic heldTaken;
	logic pending = 1'b0;
	logic holding = 1'b0;
	logic dropSeen = 1'b0;
	logic ackPrev = 1'b0;
	int edgesSince = 0;
	int resetEdges = 0;

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [`XLEN-1:0] expectedResult();
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] src;
		logic signed [`XLEN-1:0] sa;
		b = (cls == exStagePkg::aluR) ? rs2 : immL;
		sa = rs1;
		src = (f3 == exStagePkg::f3Csrrwi || f3 == exStagePkg::f3Csrrsi ||
			f3 == exStagePkg::f3Csrrci) ? {{(`XLEN-`ZIMM_WIDTH){1'b0}}, zimmL} : rs1;
		case (cls)
			exStagePkg::aluR, exStagePkg::aluIComp: begin
				case (f3)
					exStagePkg::f3AddSub: begin
						if (f7 == exStagePkg::f7Alt && cls == exStagePkg::aluR)
							return rs1 - b;
						return rs1 + b;
					end
					exStagePkg::f3Sll: return rs1 << b[4:0];
					exStagePkg::f3Slt: return ($signed(rs1) < $signed(b)) ? 1 : 0;
					exStagePkg::f3Sltu: return (rs1 < b) ? 1 : 0;
					exStagePkg::f3Xor: return rs1 ^ b;
					exStagePkg::f3Srl: begin
						if (f7 == exStagePkg::f7Alt)
							return sa >>> b[4:0];
						return rs1 >> b[4:0];
					end
					exStagePkg::f3Or: return rs1 | b;
					exStagePkg::f3And: return rs1 & b;
					default: return rs1 + b;
				endcase
			end
			exStagePkg::aluLoadStore: return rs1 + immL;
			exStagePkg::aluBranch: return rs1 - rs2;
			exStagePkg::aluLui: return immL;
			exStagePkg::aluAuipc: return pcL + immL;
			exStagePkg::aluJ: return pcL + 4;
			default: begin
				case (f3)
					exStagePkg::f3Csrrw, exStagePkg::f3Csrrwi: return src;
					exStagePkg::f3Csrrs, exStagePkg::f3Csrrsi: return csrL | src;
					exStagePkg::f3Csrrc, exStagePkg::f3Csrrci: return csrL & ~src;
					// Not a CSR form, so the register value is written through
					default: return rs1;
				endcase
			end
		endcase
	endfunction

	function automatic logic expectedTaken();
		if (cls != exStagePkg::aluBranch)
			return 1'b0;
		case (f3)
			exStagePkg::f3Beq: return rs1 == rs2;
			exStagePkg::f3Bne: return rs1 != rs2;
			exStagePkg::f3Blt: return $signed(rs1) < $signed(rs2);
			exStagePkg::f3Bge: return $signed(rs1) >= $signed(rs2);
			exStagePkg::f3Bltu: return rs1 < rs2;
			exStagePkg::f3Bgeu: return rs1 >= rs2;
			default: return 1'b0;
		endcase
	endfunction

	initial begin
		mismatchCount = 0;
		faultCount = 0;
		compareCount = 0;
	end

	//////////////////////////////
	// Monitor
	//////////////////////////////
	always @(posedge clk) begin
		if (!rstN) begin
			resetEdges++;
			// The first reset edge still sees the power-up value
			if (resetEdges > 1 && ack !== 1'b0) begin
				faultCount++;
				$display("Protocol fault at %0t: ack is not low during reset", $time);
			end
			pending = 1'b0;
			holding = 1'b0;
			dropSeen = 1'b0;
			ackPrev = 1'b0;
		end else begin
			if (dropSeen) begin
				if (ack !== 1'b0) begin
					faultCount++;
					$display("Protocol fault at %0t: ack did not fall one edge after req fell",
						$time);
				end
				holding = 1'b0;
				pending = 1'b0;
				dropSeen = 1'b0;
			end else if (ackPrev && ack !== 1'b1) begin
				faultCount++;
				$display("Protocol fault at %0t: ack fell while req was still high", $time);
				holding = 1'b0;
				pending = 1'b0;
			end
			if (pending)
				edgesSince++;
			if (ack === 1'b1 && !ackPrev) begin
				if (!pending) begin
					faultCount++;
					$display("Protocol fault at %0t: ack rose with no request in flight", $time);
				end else begin
					if (edgesSince != 2) begin
						faultCount++;
						$display("Protocol fault at %0t: ack seen %0d edges after capture, not 2",
							$time, edgesSince);
					end
					compareCount++;
					if (result !== expectedResult()) begin
						mismatchCount++;
						$display("Fail at %0t: class %0d funct3 %b result %h, expected %h",
							$time, cls, f3, result, expectedResult());
					end
					if (branchTaken !== expectedTaken()) begin
						mismatchCount++;
						$display("Fail at %0t: class %0d funct3 %b branchTaken %b, expected %b",
							$time, cls, f3, branchTaken, expectedTaken());
					end
					holding = 1'b1;
					heldResult = result;
					heldTaken = branchTaken;
				end
			end else if (holding && ack === 1'b1) begin
				if (result !== heldResult || branchTaken !== heldTaken) begin
					mismatchCount++;
					$display("Fail at %0t: outputs changed while ack was held", $time);
				end
			end else if (pending && !holding && edgesSince == 3) begin
				faultCount++;
				$display("Protocol fault at %0t: ack did not rise two edges after capture", $time);
			end
			if (holding && ack === 1'b1 && req === 1'b0)
				dropSeen = 1'b1;
			// Capture edge of a new request
			if (!pending && req === 1'b1) begin
				cls = aluCtrl;
				f3 = funct3;
				f7 = funct7;
				rs1 = rs1Data;
				rs2 = rs2Data;
				immL = imm;
				pcL = pc;
				csrL = csrRdata;
				zimmL = zimm;
				pending = 1'b1;
				edgesSince = 0;
			end
			ackPrev = (ack === 1'b1);
		end
	end

endmodule

`default_nettype wire

// ==== dv/exUnitTb.sv ====
// Testbench for the execute stage with seeded random requests and a handshake driver
`timescale 1ns/100ps
`default_nettype none

`include "exStage_settings.svh"

module exUnitTb;

	localparam int numTxns = 400;
	localparam int waitLimit = 20;

	logic clk;
	logic rstN;
	logic req;
	logic ack;
	exStagePkg::aluCtrlT aluCtrl;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] csrRdata;
	logic [`ZIMM_WIDTH-1:0] zimm;
	logic [`XLEN-1:0] result;
	logic branchTaken;
	int mismatchCount;
	int faultCount;
	int compareCount;
	int timeoutCount;
	int sentCount;
	integer seed;

	exUnit u_exUnit (
		.clk(clk), .rstN(rstN), .req(req), .ack(ack),
		.aluCtrl(aluCtrl), .funct3(funct3), .funct7(funct7),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .pc(pc),
		.csrRdata(csrRdata), .zimm(zimm), .result(result), .branchTaken(branchTaken)
	);

	exChecker u_exChecker (
		.clk(clk), .rstN(rstN), .req(req), .ack(ack),
		.aluCtrl(aluCtrl), .funct3(funct3), .funct7(funct7),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm), .pc(pc),
		.csrRdata(csrRdata), .zimm(zimm), .result(result), .branchTaken(branchTaken),
		.mismatchCount(mismatchCount), .faultCount(faultCount), .compareCount(compareCount)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic randomizeInputs();
		logic [2:0] classCode;
		logic [2:0] pick;
		classCode = $random(seed);
		pick = $random(seed);
		aluCtrl = exStagePkg::aluCtrlT'(classCode);
		funct3 = $random(seed);
		// Mostly legal codes with an odd unknown one slipping through
		if (aluCtrl == exStagePkg::aluBranch && pick != 0 && funct3[2:1] == 2'b01)
			funct3[2] = 1'b1;
		if (aluCtrl == exStagePkg::aluCsr && pick != 0 && funct3[1:0] == 2'b00)
			funct3[0] = 1'b1;
		case (pick[1:0])
			2'd0, 2'd1: funct7 = exStagePkg::f7Alt;
			2'd2: funct7 = exStagePkg::f7Base;
			default: funct7 = $random(seed);
		endcase
		rs1Data = $random(seed);
		rs2Data = (($random(seed) & 3) == 0) ? rs1Data : $random(seed);
		imm = $random(seed);
		if (pick[2])
			imm = {{(`XLEN-12){imm[11]}}, imm[11:0]};
		pc = $random(seed) & ~32'd3;
		csrRdata = $random(seed);
		zimm = $random(seed);
	endtask

	task automatic waitForAck(input logic level, output logic ok);
		int cycles;
		cycles = 0;
		while (ack !== level && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		ok = (ack === level);
	endtask

	initial begin
		logic ok;
		seed = 32'h99936828;
		timeoutCount = 0;
		sentCount = 0;
		rstN = 1'b0;
		req = 1'b0;
		aluCtrl = exStagePkg::aluR;
		funct3 = '0;
		funct7 = '0;
		rs1Data = '0;
		rs2Data = '0;
		imm = '0;
		pc = '0;
		csrRdata = '0;
		zimm = '0;
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		repeat (2) @(negedge clk);
		for (int n = 0; n < numTxns; n++) begin
			randomizeInputs();
			req = 1'b1;
			sentCount++;
			waitForAck(1'b1, ok);
			if (!ok) begin
				timeoutCount++;
				$display("Timeout at %0t: no ack for transaction %0d", $time, n);
				break;
			end
			repeat ($random(seed) & 3) @(negedge clk);
			req = 1'b0;
			waitForAck(1'b0, ok);
			if (!ok) begin
				timeoutCount++;
				$display("Timeout at %0t: ack stayed high after req fell", $time);
				break;
			end
		end
		req = 1'b0;
		repeat (3) @(negedge clk);
		$display("Mismatches %0d, protocol faults %0d, timeouts %0d, checked %0d of %0d",
			mismatchCount, faultCount, timeoutCount, compareCount, sentCount);
		if (mismatchCount == 0 && faultCount == 0 && timeoutCount == 0 &&
			compareCount == sentCount) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/exStagePkg.sv
source/exControl.sv
source/aluDecode.sv
source/operandSelect.sv
source/aluCore.sv
source/branchCompare.sv
source/exUnit.sv
dv/exChecker.sv
dv/exUnitTb.sv
